/* list.f */
hw/mips_isa_pkg.sv
hw/mips_ctrl_pkg.sv
hw/mips_ctrl_if.sv
hw/mips_alu.sv
hw/mips_regfile.sv
hw/mips_control.sv
hw/mips_datapath.sv
hw/mips_core.sv
testbench/mips_chk.sv
testbench/mips_tb.sv

/* Bender.yml */
package:
  name: mips_multicycle

sources:
  - hw/mips_isa_pkg.sv
  - hw/mips_ctrl_pkg.sv
  - hw/mips_ctrl_if.sv
  - hw/mips_alu.sv
  - hw/mips_regfile.sv
  - hw/mips_control.sv
  - hw/mips_datapath.sv
  - hw/mips_core.sv
  - target: simulation
    files:
      - testbench/mips_chk.sv
      - testbench/mips_tb.sv

/* testbench/mips_tb.sv */
module mips_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam mips_isa_pkg::word_t reset_pc = 32'h0000_0040; // program base
	localparam int max_cycles = 4000; // bound for each wait loop

	logic                clk  = 1'b0;
	logic                rstb = 1'b0;
	mips_isa_pkg::word_t mem_rd_data;
	mips_isa_pkg::word_t mem_addr;
	mips_isa_pkg::word_t mem_wr_data;
	logic                mem_wr_ena;
	mips_isa_pkg::word_t pc;

	mips_isa_pkg::word_t mem [1024];    // 4 KiB of code and data
	mips_isa_pkg::word_t exp_addr_q [$]; // store order from the reference
	mips_isa_pkg::word_t exp_data_q [$];
	mips_isa_pkg::word_t exp_addr;
	mips_isa_pkg::word_t exp_data;
	mips_isa_pkg::word_t halt_pc;        // self-jump at program end
	mips_isa_pkg::word_t ref_pc;
	integer              seed = 32'hf66d;
	int                  wp;             // program word pointer
	int                  st_off;         // next store offset from r20
	int                  n_exp;
	int                  store_cnt = 0;

	mips_core #(
		.reset_pc (reset_pc)
	) UUT (
		.clk         (clk),
		.rstb        (rstb),
		.mem_rd_data (mem_rd_data),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_ena  (mem_wr_ena),
		.pc          (pc)
	);

	initial begin
		forever #2 clk = ~clk; // 4 ns period
	end

	// memory reads comb and writes on the strobed edge
	assign mem_rd_data = mem[mem_addr[11:2]];

	always @(posedge clk) begin
		if (mem_wr_ena === 1'b1)
			mem[mem_addr[11:2]] <= mem_wr_data;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// instruction encoders
	function automatic mips_isa_pkg::word_t r_type(input mips_isa_pkg::funct_t fn,
			input mips_isa_pkg::reg_addr_t rs, input mips_isa_pkg::reg_addr_t rt,
			input mips_isa_pkg::reg_addr_t rd, input mips_isa_pkg::shamt_t sh);
		return {mips_isa_pkg::op_rtype, rs, rt, rd, sh, fn};
	endfunction

	function automatic mips_isa_pkg::word_t i_type(input mips_isa_pkg::opcode_t op,
			input mips_isa_pkg::reg_addr_t rs, input mips_isa_pkg::reg_addr_t rt,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_isa_pkg::word_t j_type(input mips_isa_pkg::opcode_t op,
			input mips_isa_pkg::word_t target);
		return {op, target[27:2]}; // upper nibble comes from pc
	endfunction

	function automatic mips_isa_pkg::word_t next_addr();
		return mips_isa_pkg::word_t'(wp * 4);
	endfunction

	task automatic emit(input mips_isa_pkg::word_t ins);
		mem[wp] = ins;
		wp++;
	endtask

	// full 32-bit constant from addi upper half then shift and ori lower half
	task automatic load_const(input mips_isa_pkg::reg_addr_t rd, input mips_isa_pkg::word_t value);
		emit(i_type(mips_isa_pkg::op_addi, 5'd0, rd, value[31:16])); // sign bits shifted out below
		emit(r_type(mips_isa_pkg::fn_sll, 5'd0, rd, rd, 5'd16));
		emit(i_type(mips_isa_pkg::op_ori, rd, rd, value[15:0]));
	endtask

	task automatic store_reg(input mips_isa_pkg::reg_addr_t rt);
		emit(i_type(mips_isa_pkg::op_sw, 5'd20, rt, st_off[15:0])); // sw rt, st_off(r20)
		st_off += 4;
	endtask

	task automatic build_program();
		logic [15:0]          imm;
		mips_isa_pkg::shamt_t sh;
		mips_isa_pkg::word_t  tgt;
		for (int i = 0; i < 1024; i++)
			mem[i] = 32'hbad0_0000 | (i * 4); // fill tagged with byte address
		wp     = int'(reset_pc >> 2);
		st_off = 0;
		emit(i_type(mips_isa_pkg::op_addi, 5'd0, 5'd20, 16'h0800)); // data base
		load_const(5'd1, $random(seed));
		load_const(5'd2, $random(seed));
		load_const(5'd3, $random(seed) | 32'h8000_0000); // negative operand
		load_const(5'd4, $random(seed) & 32'h7fff_ffff); // positive operand
		emit(r_type(mips_isa_pkg::fn_add, 5'd1, 5'd2, 5'd5, 5'd0));
		store_reg(5'd5); // offset 0 is read back by lw below
		emit(r_type(mips_isa_pkg::fn_sub, 5'd1, 5'd2, 5'd5, 5'd0));
		store_reg(5'd5);
		emit(r_type(mips_isa_pkg::fn_and, 5'd1, 5'd2, 5'd5, 5'd0));
		store_reg(5'd5);
		emit(r_type(mips_isa_pkg::fn_or, 5'd1, 5'd2, 5'd5, 5'd0));
		store_reg(5'd5);
		emit(r_type(mips_isa_pkg::fn_slt, 5'd3, 5'd4, 5'd5, 5'd0)); // neg < pos
		store_reg(5'd5);
		emit(r_type(mips_isa_pkg::fn_slt, 5'd4, 5'd3, 5'd5, 5'd0));
		store_reg(5'd5);
		emit(r_type(mips_isa_pkg::fn_slt, 5'd1, 5'd2, 5'd5, 5'd0));
		store_reg(5'd5);
		sh = 5'($random(seed)) | 5'd1; // never a zero shift
		emit(r_type(mips_isa_pkg::fn_sll, 5'd0, 5'd1, 5'd5, sh));
		store_reg(5'd5);
		// immediates with bit 15 set
		imm = 16'($random(seed)) | 16'h8000;
		emit(i_type(mips_isa_pkg::op_addi, 5'd1, 5'd6, imm));
		store_reg(5'd6);
		imm = 16'($random(seed)) | 16'h8000;
		emit(i_type(mips_isa_pkg::op_andi, 5'd3, 5'd6, imm)); // upper bits of r3 must clear
		store_reg(5'd6);
		imm = 16'($random(seed)) | 16'h8000;
		emit(i_type(mips_isa_pkg::op_ori, 5'd0, 5'd6, imm));
		store_reg(5'd6);
		emit(i_type(mips_isa_pkg::op_addi, 5'd1, 5'd0, 16'h0005)); // write to r0 is dropped
		store_reg(5'd0);
		emit(i_type(mips_isa_pkg::op_lw, 5'd20, 5'd7, 16'h0000)); // add result
		store_reg(5'd7);
		emit(i_type(mips_isa_pkg::op_lw, 5'd20, 5'd8, 16'h0400)); // untouched fill word
		store_reg(5'd8);
		// branches skip one store when taken
		emit(i_type(mips_isa_pkg::op_beq, 5'd1, 5'd1, 16'd1));
		store_reg(5'd2);
		emit(i_type(mips_isa_pkg::op_bne, 5'd1, 5'd1, 16'd1));
		store_reg(5'd3);
		emit(i_type(mips_isa_pkg::op_beq, 5'd1, 5'd2, 16'd1));
		store_reg(5'd4);
		emit(i_type(mips_isa_pkg::op_bne, 5'd1, 5'd2, 16'd1));
		store_reg(5'd1);
		tgt = next_addr() + 8;
		emit(j_type(mips_isa_pkg::op_j, tgt));
		store_reg(5'd2); // jumped over
		tgt = next_addr() + 8;
		emit(j_type(mips_isa_pkg::op_jal, tgt));
		store_reg(5'd2); // jumped over
		store_reg(5'd31); // return address from jal
		halt_pc = next_addr();
		emit(j_type(mips_isa_pkg::op_j, halt_pc));
	endtask

	// behavioral isa model without delay slots that fills the expected store queues
	function automatic mips_isa_pkg::word_t ref_run(input mips_isa_pkg::word_t start_pc,
			input int max_steps);
		mips_isa_pkg::word_t regs [32];
		mips_isa_pkg::word_t rmem [1024];
		mips_isa_pkg::word_t rpc;
		mips_isa_pkg::word_t ins;
		mips_isa_pkg::word_t rs_v;
		mips_isa_pkg::word_t rt_v;
		mips_isa_pkg::word_t imm_s;
		mips_isa_pkg::word_t ea;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		rmem = mem;
		rpc  = start_pc;
		for (int step = 0; step < max_steps; step++) begin
			ins   = rmem[rpc[11:2]];
			rs_v  = regs[ins[25:21]];
			rt_v  = regs[ins[20:16]];
			imm_s = {{16{ins[15]}}, ins[15:0]};
			ea    = rs_v + imm_s;
			if (ins[31:26] == mips_isa_pkg::op_j && {rpc[31:28], ins[25:0], 2'b00} == rpc)
				return rpc; // halt loop
			rpc = rpc + 4;
			case (ins[31:26])
				mips_isa_pkg::op_rtype: begin
					case (ins[5:0])
						mips_isa_pkg::fn_add: regs[ins[15:11]] = rs_v + rt_v;
						mips_isa_pkg::fn_sub: regs[ins[15:11]] = rs_v - rt_v;
						mips_isa_pkg::fn_and: regs[ins[15:11]] = rs_v & rt_v;
						mips_isa_pkg::fn_or:  regs[ins[15:11]] = rs_v | rt_v;
						mips_isa_pkg::fn_slt:
							regs[ins[15:11]] = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
						mips_isa_pkg::fn_sll: regs[ins[15:11]] = rt_v << ins[10:6];
						default: ;
					endcase
				end
				mips_isa_pkg::op_addi: regs[ins[20:16]] = ea;
				mips_isa_pkg::op_andi: regs[ins[20:16]] = rs_v & {16'h0000, ins[15:0]};
				mips_isa_pkg::op_ori:  regs[ins[20:16]] = rs_v | {16'h0000, ins[15:0]};
				mips_isa_pkg::op_lw:   regs[ins[20:16]] = rmem[ea[11:2]];
				mips_isa_pkg::op_sw: begin
					rmem[ea[11:2]] = rt_v;
					exp_addr_q.push_back(ea);
					exp_data_q.push_back(rt_v);
				end
				mips_isa_pkg::op_beq: if (rs_v == rt_v) rpc = rpc + {imm_s[29:0], 2'b00};
				mips_isa_pkg::op_bne: if (rs_v != rt_v) rpc = rpc + {imm_s[29:0], 2'b00};
				mips_isa_pkg::op_j:   rpc = {rpc[31:28], ins[25:0], 2'b00};
				mips_isa_pkg::op_jal: begin
					regs[31] = rpc; // already the return address
					rpc      = {rpc[31:28], ins[25:0], 2'b00};
				end
				default: ;
			endcase
			regs[0] = '0;
		end
		return '1; // ran out of steps
	endfunction

	task automatic wait_for_pc(input mips_isa_pkg::word_t target);
		int cycles;
		cycles = 0;
		while (pc !== target && cycles < max_cycles) begin
			@(negedge clk);
			cycles++;
		end
		assert (pc === target)
		else abort_run($sformatf("program never reached the halt loop at %h", target));
	endtask

	// store compare in reference order
	always @(posedge clk) begin
		if (rstb === 1'b1 && mem_wr_ena === 1'b1) begin
			assert (exp_addr_q.size() > 0)
			else abort_run($sformatf("[ERROR] %0d ns: unexpected store to %h", $time, mem_addr));
			exp_addr = exp_addr_q.pop_front();
			exp_data = exp_data_q.pop_front();
			assert (mem_addr === exp_addr && mem_wr_data === exp_data)
			else abort_run($sformatf("[ERROR] %0d ns: store %0d wrote %h to %h, expected %h to %h",
				$time, store_cnt, mem_wr_data, mem_addr, exp_data, exp_addr));
			store_cnt++;
		end
	end

	initial begin
		build_program();
		ref_pc = ref_run(reset_pc, 5000);
		n_exp  = exp_addr_q.size();
		assert (ref_pc === halt_pc)
		else abort_run("reference model never reached the halt loop");
		repeat (16) @(posedge clk);
		rstb <= 1'b1;
		@(negedge clk);
		assert (mem_addr === reset_pc)
		else abort_run($sformatf("[ERROR] %0d ns: first fetch from %h, expected %h",
			$time, mem_addr, reset_pc));
		// pc hits halt_pc already while the last sw runs, so go round the loop once
		wait_for_pc(halt_pc);
		wait_for_pc(halt_pc + 4);
		wait_for_pc(halt_pc);
		assert (store_cnt == n_exp && exp_addr_q.size() == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			abort_run($sformatf("[ERROR] %0d ns: %0d stores seen, expected %0d",
				$time, store_cnt, n_exp));
		end
	end

endmodule

/* testbench/mips_chk.sv */
module mips_chk (
	input logic                clk,
	input logic                rstb,
	input logic                mem_wr_ena,
	input mips_isa_pkg::word_t pc
);
	timeunit 1ns;
	timeprecision 100ps;

	// store strobe lasts one cycle only
	single_strobe: assert property (@(posedge clk) disable iff (!rstb)
		mem_wr_ena |=> !mem_wr_ena)
		else $error("mem_wr_ena high on two consecutive cycles");

	pc_aligned: assert property (@(posedge clk) disable iff (!rstb)
		pc[1:0] == 2'b00) // word fetches only
		else $error("pc %h not word aligned", pc);

	// no memory write while in reset
	quiet_reset: assert property (@(posedge clk)
		!rstb |-> !mem_wr_ena)
		else $error("mem_wr_ena high during reset");

endmodule

bind mips_core mips_chk chk (
	.clk        (clk),
	.rstb       (rstb),
	.mem_wr_ena (mem_wr_ena),
	.pc         (pc)
);

/* hw/mips_core.sv */
module mips_core #(
	parameter mips_isa_pkg::word_t reset_pc = 32'h0000_0000
) (
	input  logic                clk,
	input  logic                rstb,
	input  mips_isa_pkg::word_t mem_rd_data, // comb read of mem_addr
	output mips_isa_pkg::word_t mem_addr,
	output mips_isa_pkg::word_t mem_wr_data,
	output logic                mem_wr_ena,  // write on this rising edge
	output mips_isa_pkg::word_t pc
);

	mips_ctrl_if ctrl_bus ();

	mips_isa_pkg::word_t instr; // ir for decode

	mips_control control (
		.clk   (clk),
		.rstb  (rstb),
		.instr (instr),
		.ctrl  (ctrl_bus.ctrl)
	);

	// zero flag is consumed inside the datapath for branches
	mips_datapath #(
		.reset_pc (reset_pc)
	) datapath (
		.clk         (clk),
		.rstb        (rstb),
		.ctrl        (ctrl_bus.dp),
		.mem_rd_data (mem_rd_data),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.instr       (instr),
		.zero        (),
		.pc          (pc)
	);

	assign mem_wr_ena = ctrl_bus.mem_wr;

endmodule

/* hw/mips_datapath.sv */
module mips_datapath #(
	parameter mips_isa_pkg::word_t reset_pc = 32'h0000_0000
) (
	input  logic                clk,
	input  logic                rstb,
	mips_ctrl_if.dp             ctrl,
	input  mips_isa_pkg::word_t mem_rd_data, // instruction or load data
	output mips_isa_pkg::word_t mem_addr,
	output mips_isa_pkg::word_t mem_wr_data,
	output mips_isa_pkg::word_t instr,       // ir back to control
	output logic                zero,
	output mips_isa_pkg::word_t pc
);

	// architectural registers besides pc
	mips_isa_pkg::word_t ir;
	mips_isa_pkg::word_t mdr;
	mips_isa_pkg::word_t reg_a;
	mips_isa_pkg::word_t reg_b;
	mips_isa_pkg::word_t alu_out;

	mips_isa_pkg::word_t     rs_data;
	mips_isa_pkg::word_t     rt_data;
	mips_isa_pkg::word_t     imm_ext;    // extended immediate
	mips_isa_pkg::word_t     op_a;
	mips_isa_pkg::word_t     op_b;
	mips_isa_pkg::word_t     alu_result;
	mips_isa_pkg::word_t     pc_next;
	mips_isa_pkg::word_t     wr_data;
	mips_isa_pkg::reg_addr_t wr_addr;
	mips_isa_pkg::shamt_t    shamt;
	logic                    take_branch;

	assign shamt   = ir[10:6];
	assign imm_ext = ctrl.zero_ext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

	// operand muxes
	always_comb begin
		case (ctrl.src_a)
			mips_ctrl_pkg::sa_pc:    op_a = pc;
			mips_ctrl_pkg::sa_shamt: op_a = {27'd0, shamt};
			default:                 op_a = reg_a;
		endcase
		case (ctrl.src_b)
			mips_ctrl_pkg::sb_imm:     op_b = imm_ext;
			mips_ctrl_pkg::sb_four:    op_b = 32'd4;
			mips_ctrl_pkg::sb_imm_sh2: op_b = {imm_ext[29:0], 2'b00}; // word offset
			default:                   op_b = reg_b;
		endcase
	end

	mips_alu alu (
		.a      (op_a),
		.b      (op_b),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.zero   (zero)
	);

	// write destination and data
	always_comb begin
		case (ctrl.reg_dst)
			mips_ctrl_pkg::rd_rd:   wr_addr = ir[15:11];
			mips_ctrl_pkg::rd_link: wr_addr = mips_isa_pkg::link_reg;
			default:                wr_addr = ir[20:16];
		endcase
		if (ctrl.reg_dst == mips_ctrl_pkg::rd_link)
			wr_data = pc; // return address
		else
			wr_data = ctrl.mem_to_reg ? mdr : alu_out;
	end

	mips_regfile regfile (
		.clk     (clk),
		.rs_addr (ir[25:21]),
		.rt_addr (ir[20:16]),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_ena  (ctrl.reg_wr),
		.rs_data (rs_data),
		.rt_data (rt_data)
	);

	// branch qualify and pc source
	assign take_branch = ((ctrl.branch == mips_ctrl_pkg::br_eq) &&  zero) ||
	                     ((ctrl.branch == mips_ctrl_pkg::br_ne) && !zero);

	always_comb begin
		case (ctrl.pc_src)
			mips_ctrl_pkg::ps_alu_out: pc_next = alu_out;
			mips_ctrl_pkg::ps_jump:    pc_next = {pc[31:28], ir[25:0], 2'b00};
			default:                   pc_next = alu_result; // pc+4
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstb) begin
			pc      <= reset_pc;
			ir      <= '0;
			mdr     <= '0;
			reg_a   <= '0;
			reg_b   <= '0;
			alu_out <= '0;
		end else begin
			reg_a   <= rs_data; // operands follow ir every cycle
			reg_b   <= rt_data;
			alu_out <= alu_result;
			mdr     <= mem_rd_data;
			if (ctrl.ir_wr)
				ir <= mem_rd_data;
			if (ctrl.pc_wr || take_branch)
				pc <= pc_next;
		end
	end

	assign mem_addr    = ctrl.iord ? alu_out : pc;
	assign mem_wr_data = reg_b; // sw source is rt
	assign instr       = ir;

endmodule

/* hw/mips_control.sv */
module mips_control (
	input  logic                clk,
	input  logic                rstb,
	input  mips_isa_pkg::word_t instr, // from ir
	mips_ctrl_if.ctrl           ctrl
);

	mips_ctrl_pkg::state_t   state;
	mips_ctrl_pkg::state_t   state_nxt;
	mips_isa_pkg::opcode_t   opcode;
	mips_isa_pkg::funct_t    funct;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];

	// r-type funct to alu operation
	function automatic mips_ctrl_pkg::alu_op_t funct_to_alu(input mips_isa_pkg::funct_t f);
		case (f)
			mips_isa_pkg::fn_sub: return mips_ctrl_pkg::alu_sub;
			mips_isa_pkg::fn_and: return mips_ctrl_pkg::alu_and;
			mips_isa_pkg::fn_or:  return mips_ctrl_pkg::alu_or;
			mips_isa_pkg::fn_slt: return mips_ctrl_pkg::alu_slt;
			mips_isa_pkg::fn_sll: return mips_ctrl_pkg::alu_sll;
			default:              return mips_ctrl_pkg::alu_add; // fn_add and unknowns
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (!rstb)
			state <= mips_ctrl_pkg::st_fetch;
		else
			state <= state_nxt;
	end

	// next state
	always_comb begin
		state_nxt = mips_ctrl_pkg::st_fetch; // most paths return to fetch
		case (state)
			mips_ctrl_pkg::st_fetch: state_nxt = mips_ctrl_pkg::st_decode;
			mips_ctrl_pkg::st_decode: begin
				case (opcode)
					mips_isa_pkg::op_lw,
					mips_isa_pkg::op_sw:    state_nxt = mips_ctrl_pkg::st_mem_addr;
					mips_isa_pkg::op_rtype: state_nxt = mips_ctrl_pkg::st_r_exec;
					mips_isa_pkg::op_addi,
					mips_isa_pkg::op_andi,
					mips_isa_pkg::op_ori:   state_nxt = mips_ctrl_pkg::st_i_exec;
					mips_isa_pkg::op_beq,
					mips_isa_pkg::op_bne:   state_nxt = mips_ctrl_pkg::st_branch;
					mips_isa_pkg::op_j:     state_nxt = mips_ctrl_pkg::st_jump;
					mips_isa_pkg::op_jal:   state_nxt = mips_ctrl_pkg::st_jal;
					default:                state_nxt = mips_ctrl_pkg::st_fetch; // skip unknown
				endcase
			end
			mips_ctrl_pkg::st_mem_addr:
				state_nxt = (opcode == mips_isa_pkg::op_lw) ? mips_ctrl_pkg::st_mem_read
				                                            : mips_ctrl_pkg::st_mem_write;
			mips_ctrl_pkg::st_mem_read: state_nxt = mips_ctrl_pkg::st_mem_wb;
			mips_ctrl_pkg::st_r_exec:   state_nxt = mips_ctrl_pkg::st_alu_wb;
			mips_ctrl_pkg::st_i_exec:   state_nxt = mips_ctrl_pkg::st_alu_wb;
			default:                    state_nxt = mips_ctrl_pkg::st_fetch;
		endcase
	end

	// control lines per state, idle defaults first
	always_comb begin
		ctrl.pc_wr      = 1'b0;
		ctrl.ir_wr      = 1'b0;
		ctrl.reg_wr     = 1'b0;
		ctrl.mem_wr     = 1'b0; // stays low for an unknown state during reset
		ctrl.mem_to_reg = 1'b0;
		ctrl.iord       = 1'b0;
		ctrl.zero_ext   = 1'b0;
		ctrl.src_a      = mips_ctrl_pkg::sa_reg_a;
		ctrl.src_b      = mips_ctrl_pkg::sb_reg_b;
		ctrl.reg_dst    = mips_ctrl_pkg::rd_rt;
		ctrl.pc_src     = mips_ctrl_pkg::ps_alu;
		ctrl.branch     = mips_ctrl_pkg::br_none;
		ctrl.alu_op     = mips_ctrl_pkg::alu_add;
		case (state)
			mips_ctrl_pkg::st_fetch: begin // ir <= mem[pc], pc <= pc+4
				ctrl.ir_wr = 1'b1;
				ctrl.pc_wr = 1'b1;
				ctrl.src_a = mips_ctrl_pkg::sa_pc;
				ctrl.src_b = mips_ctrl_pkg::sb_four;
			end
			mips_ctrl_pkg::st_decode: begin // speculative branch target into alu_out
				ctrl.src_a = mips_ctrl_pkg::sa_pc;
				ctrl.src_b = mips_ctrl_pkg::sb_imm_sh2;
			end
			mips_ctrl_pkg::st_mem_addr,
			mips_ctrl_pkg::st_mem_read: begin
				ctrl.src_b = mips_ctrl_pkg::sb_imm; // keep a+imm stable in alu_out
				ctrl.iord  = (state == mips_ctrl_pkg::st_mem_read);
			end
			mips_ctrl_pkg::st_mem_write: begin
				ctrl.src_b  = mips_ctrl_pkg::sb_imm;
				ctrl.iord   = 1'b1;
				ctrl.mem_wr = 1'b1; // single cycle strobe
			end
			mips_ctrl_pkg::st_mem_wb: begin
				ctrl.reg_wr     = 1'b1;
				ctrl.mem_to_reg = 1'b1; // rt <= mdr
			end
			mips_ctrl_pkg::st_r_exec: begin
				ctrl.alu_op = funct_to_alu(funct);
				if (funct == mips_isa_pkg::fn_sll)
					ctrl.src_a = mips_ctrl_pkg::sa_shamt;
			end
			mips_ctrl_pkg::st_i_exec: begin
				ctrl.src_b = mips_ctrl_pkg::sb_imm;
				case (opcode)
					mips_isa_pkg::op_andi: ctrl.alu_op = mips_ctrl_pkg::alu_and;
					mips_isa_pkg::op_ori:  ctrl.alu_op = mips_ctrl_pkg::alu_or;
					default:               ctrl.alu_op = mips_ctrl_pkg::alu_add; // addi
				endcase
				ctrl.zero_ext = (opcode == mips_isa_pkg::op_andi) ||
				                (opcode == mips_isa_pkg::op_ori);
			end
			mips_ctrl_pkg::st_alu_wb: begin
				ctrl.reg_wr  = 1'b1;
				ctrl.reg_dst = (opcode == mips_isa_pkg::op_rtype) ? mips_ctrl_pkg::rd_rd
				                                                  : mips_ctrl_pkg::rd_rt;
			end
			mips_ctrl_pkg::st_branch: begin // compare a-b, target already in alu_out
				ctrl.alu_op = mips_ctrl_pkg::alu_sub;
				ctrl.pc_src = mips_ctrl_pkg::ps_alu_out;
				ctrl.branch = (opcode == mips_isa_pkg::op_beq) ? mips_ctrl_pkg::br_eq
				                                               : mips_ctrl_pkg::br_ne;
			end
			mips_ctrl_pkg::st_jump,
			mips_ctrl_pkg::st_jal: begin
				ctrl.pc_wr  = 1'b1;
				ctrl.pc_src = mips_ctrl_pkg::ps_jump;
				if (state == mips_ctrl_pkg::st_jal) begin
					ctrl.reg_wr  = 1'b1; // r31 <= pc, already pc+4
					ctrl.reg_dst = mips_ctrl_pkg::rd_link;
				end
			end
			default: ;
		endcase
	end

endmodule

/* hw/mips_regfile.sv */
module mips_regfile (
	input  logic                    clk,
	input  mips_isa_pkg::reg_addr_t rs_addr,
	input  mips_isa_pkg::reg_addr_t rt_addr,
	input  mips_isa_pkg::reg_addr_t wr_addr,
	input  mips_isa_pkg::word_t     wr_data,
	input  logic                    wr_ena,
	output mips_isa_pkg::word_t     rs_data,
	output mips_isa_pkg::word_t     rt_data
);

	mips_isa_pkg::word_t regs [32]; // entry 0 never written

	// single write port
	always_ff @(posedge clk) begin
		if (wr_ena && (wr_addr != '0))
			regs[wr_addr] <= wr_data;
	end

	// async reads, r0 hardwired to zero
	assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
	assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

/* hw/mips_alu.sv */
module mips_alu (
	input  mips_isa_pkg::word_t    a,
	input  mips_isa_pkg::word_t    b,
	input  mips_ctrl_pkg::alu_op_t op,
	output mips_isa_pkg::word_t    result,
	output logic                   zero
);

	always_comb begin
		case (op)
			mips_ctrl_pkg::alu_add:
				result = a + b;
			mips_ctrl_pkg::alu_sub:
				result = a - b; // also used for beq/bne compare
			mips_ctrl_pkg::alu_and:
				result = a & b;
			mips_ctrl_pkg::alu_or:
				result = a | b;
			mips_ctrl_pkg::alu_slt:
				result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			mips_ctrl_pkg::alu_sll:
				result = b << a[4:0]; // a carries shamt
			default:
				result = '0;
		endcase
	end

	// branch compare flag
	assign zero = (result == '0);

endmodule

/* hw/mips_ctrl_if.sv */
interface mips_ctrl_if;

	// write enables
	logic pc_wr;      // unconditional pc load
	logic ir_wr;      // latch fetched instruction
	logic reg_wr;     // register file write
	logic mem_wr;     // store strobe, one cycle

	// data path steering
	logic mem_to_reg; // writeback from mdr instead of alu_out
	logic iord;       // mem address from alu_out
	logic zero_ext;   // andi/ori immediates

	mips_ctrl_pkg::src_a_t   src_a;
	mips_ctrl_pkg::src_b_t   src_b;
	mips_ctrl_pkg::reg_dst_t reg_dst;
	mips_ctrl_pkg::pc_src_t  pc_src;
	mips_ctrl_pkg::branch_t  branch; // conditional pc load
	mips_ctrl_pkg::alu_op_t  alu_op;

	// control unit side
	modport ctrl (
		output pc_wr, ir_wr, reg_wr, mem_wr, mem_to_reg, iord, zero_ext,
		output src_a, src_b, reg_dst, pc_src, branch, alu_op
	);

	// datapath side
	modport dp (
		input pc_wr, ir_wr, reg_wr, mem_wr, mem_to_reg, iord, zero_ext,
		input src_a, src_b, reg_dst, pc_src, branch, alu_op
	);

endinterface

/* hw/mips_ctrl_pkg.sv */
package mips_ctrl_pkg;

	// alu operation select
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt, // signed set-less-than
		alu_sll  // b << a[4:0]
	} alu_op_t;

	// alu operand a source
	typedef enum logic [1:0] {
		sa_reg_a, // register a
		sa_pc,
		sa_shamt  // shift amount from ir
	} src_a_t;

	// alu operand b source
	typedef enum logic [1:0] {
		sb_reg_b,  // register b
		sb_imm,    // extended immediate
		sb_four,   // pc increment
		sb_imm_sh2 // branch offset in words
	} src_b_t;

	// register file write destination
	typedef enum logic [1:0] {
		rd_rt,  // i-type and lw
		rd_rd,  // r-type
		rd_link // jal return address
	} reg_dst_t;

	// next pc source
	typedef enum logic [1:0] {
		ps_alu_out, // registered branch target
		ps_alu,     // pc+4 straight from the alu
		ps_jump     // {pc[31:28], index, 00}
	} pc_src_t;

	// branch condition
	typedef enum logic [1:0] {
		br_none,
		br_eq,
		br_ne
	} branch_t;

	// multicycle fsm states
	typedef enum logic [3:0] {
		st_fetch,
		st_decode,
		st_mem_addr,
		st_mem_read,
		st_mem_wb,
		st_mem_write,
		st_r_exec,
		st_alu_wb,
		st_i_exec,
		st_branch,
		st_jump,
		st_jal
	} state_t;

endpackage

/* hw/mips_isa_pkg.sv */
package mips_isa_pkg;

	// basic widths of the instruction set
	typedef logic [31:0] word_t;     // data or address word
	typedef logic [4:0]  reg_addr_t; // register index
	typedef logic [5:0]  opcode_t;   // instr[31:26]
	typedef logic [5:0]  funct_t;    // instr[5:0] for r-type
	typedef logic [4:0]  shamt_t;    // instr[10:6]

	// primary opcodes
	localparam opcode_t op_rtype = 6'h00; // decode via funct
	localparam opcode_t op_j     = 6'h02;
	localparam opcode_t op_jal   = 6'h03; // jump and link to r31
	localparam opcode_t op_beq   = 6'h04;
	localparam opcode_t op_bne   = 6'h05;
	localparam opcode_t op_addi  = 6'h08; // sign-extended imm
	localparam opcode_t op_andi  = 6'h0c; // zero-extended imm
	localparam opcode_t op_ori   = 6'h0d; // zero-extended imm
	localparam opcode_t op_lw    = 6'h23;
	localparam opcode_t op_sw    = 6'h2b;

	// r-type function codes
	localparam funct_t fn_sll = 6'h00; // rd = rt << shamt
	localparam funct_t fn_add = 6'h20;
	localparam funct_t fn_sub = 6'h22;
	localparam funct_t fn_and = 6'h24;
	localparam funct_t fn_or  = 6'h25;
	localparam funct_t fn_slt = 6'h2a; // signed compare

	// jal destination
	localparam reg_addr_t link_reg = 5'd31;

	// instruction field positions, for reference
	//   [31:26] opcode
	//   [25:21] rs
	//   [20:16] rt
	//   [15:11] rd
	//   [10:6]  shamt
	//   [5:0]   funct
	//   [15:0]  immediate
	//   [25:0]  jump index

endpackage
